// ==== include/mine_defs.svh ====
`ifndef MINE_DEFS_SVH
`define MINE_DEFS_SVH

// board limits
`define MINE_BOARD_X_MAX 20
`define MINE_BOARD_Y_MAX 16
`define MINE_X_W 5
`define MINE_Y_W 4

// cell address is {column, row}
`define MINE_ADDR_W 9
`define MINE_DEPTH (`MINE_BOARD_X_MAX * `MINE_BOARD_Y_MAX)
`define MINE_COUNT_W 9

// random source
`define MINE_LFSR_W 32
`define MINE_LFSR_COUNT 4
`define MINE_FIELDS_PER_LFSR 3

`define MINE_SEED_0 32'hC0FFEE11
`define MINE_SEED_1 32'h3A5C96E1
`define MINE_SEED_2 32'h9B17D24F
`define MINE_SEED_3 32'h6D2E48B3

`endif

// ==== hw/mine_pkg.sv ====
`include "mine_defs.svh"

package mine_pkg;

	// controller states
	typedef enum logic [2:0] {
		ST_IDLE,
		ST_CLEAR,
		ST_PROBE,
		ST_DECIDE,
		ST_FINISH
	} mine_state_t;

	typedef logic [`MINE_ADDR_W-1:0] cell_addr_t;
	typedef logic [`MINE_COUNT_W-1:0] mine_count_t;
	typedef logic [`MINE_LFSR_W-1:0] lfsr_word_t;

endpackage

// ==== hw/mine_lfsr.sv ====
`timescale 1ns/1ns

`include "mine_defs.svh"

module mine_lfsr (
	input logic clock,
	input logic resetn,
	input mine_pkg::lfsr_word_t seed,
	input logic load,
	input logic shift,
	output mine_pkg::lfsr_word_t state
);

	logic feedback;

	// taps 22, 2, 1, 0 feed the new low bit
	assign feedback = state[22] ^ state[2] ^ state[1] ^ state[0];

	always_ff @(posedge clock) begin
		if (!resetn) begin
			state <= '0;
		end else if (load) begin
			state <= seed;
		end else if (shift) begin
			state <= {state[`MINE_LFSR_W-2:0], feedback};
		end
	end

endmodule

// ==== hw/mine_site_gen.sv ====
`timescale 1ns/1ns

`include "mine_defs.svh"

module mine_site_gen (
	input logic clock,
	input logic resetn,
	input logic load_seeds,
	input logic shift,
	input mine_pkg::mine_count_t placed,
	input logic [`MINE_X_W-1:0] board_x,
	input logic [`MINE_Y_W-1:0] board_y,
	output mine_pkg::cell_addr_t site_addr
);

	localparam int NUM_FIELDS = `MINE_LFSR_COUNT * `MINE_FIELDS_PER_LFSR;

	localparam mine_pkg::lfsr_word_t SEEDS [`MINE_LFSR_COUNT] = '{
		`MINE_SEED_0,
		`MINE_SEED_1,
		`MINE_SEED_2,
		`MINE_SEED_3
	};

	mine_pkg::lfsr_word_t lfsr_state [`MINE_LFSR_COUNT];
	mine_pkg::cell_addr_t fields [NUM_FIELDS];
	mine_pkg::cell_addr_t site_raw;
	logic [3:0] field_idx;
	logic [`MINE_X_W-1:0] col_raw;
	logic [`MINE_X_W-1:0] col_wrap;
	logic [`MINE_X_W-1:0] row_wrap;

	// reduce value into 0..bound-1, largest multiple first
	function automatic logic [`MINE_X_W-1:0] wrap_bound(
		input logic [`MINE_X_W-1:0] value,
		input logic [`MINE_X_W-1:0] bound
	);
		logic [10:0] multiple;
		logic [10:0] wide_value;
		logic [`MINE_X_W-1:0] result;
		logic found;
		int k;
		wide_value = 11'(value);
		result = value;
		found = 1'b0;
		for (k = 31; k >= 1; k--) begin
			multiple = 11'(bound) * 11'(k);
			if (!found && wide_value >= multiple) begin
				result = `MINE_X_W'(wide_value - multiple);
				found = 1'b1;
			end
		end
		return result;
	endfunction

	for (genvar g = 0; g < `MINE_LFSR_COUNT; g++) begin : g_lfsr
		mine_lfsr u_lfsr (
			.clock(clock),
			.resetn(resetn),
			.seed(SEEDS[g]),
			.load(load_seeds),
			.shift(shift),
			.state(lfsr_state[g])
		);

		// three whole 9-bit fields per generator, top bits unused
		for (genvar f = 0; f < `MINE_FIELDS_PER_LFSR; f++) begin : g_field
			assign fields[g * `MINE_FIELDS_PER_LFSR + f] =
				lfsr_state[g][f * `MINE_ADDR_W +: `MINE_ADDR_W];
		end
	end

	assign field_idx = 4'(placed % 9'(NUM_FIELDS));
	assign site_raw = fields[field_idx];

	assign col_raw = site_raw[`MINE_ADDR_W-1:`MINE_Y_W];
	assign col_wrap = wrap_bound(col_raw, board_x);
	// row goes through the same reducer, zero extended
	assign row_wrap = wrap_bound({1'b0, site_raw[`MINE_Y_W-1:0]}, {1'b0, board_y});

	assign site_addr = {col_wrap, row_wrap[`MINE_Y_W-1:0]};

endmodule

// ==== hw/mine_board_ram.sv ====
`timescale 1ns/1ns

`include "mine_defs.svh"

module mine_board_ram (
	input logic clock,
	input mine_pkg::cell_addr_t addr,
	input logic we,
	input logic wdata,
	output logic rdata
);

	logic mem [`MINE_DEPTH];
	logic in_range;

	// columns past the widest board read as empty
	assign in_range = (addr < `MINE_DEPTH);

	always_ff @(posedge clock) begin
		if (we) begin
			mem[addr] <= wdata;
		end
		if (in_range) begin
			rdata <= mem[addr];
		end else begin
			rdata <= 1'b0;
		end
	end

	// the controller never sweeps or places past the last cell
	a_write_in_range: assert property (
		@(posedge clock) we |-> (addr < `MINE_DEPTH)
	) else $error("mine_board_ram: write to address %0d", addr);

endmodule

// ==== hw/mine_layer_ctrl.sv ====
`timescale 1ns/1ns

`include "mine_defs.svh"

module mine_layer_ctrl (
	input logic clock,
	input logic resetn,
	input logic start,
	input mine_pkg::mine_count_t num_mines,
	input mine_pkg::cell_addr_t site_addr,
	input logic rdata,
	output mine_pkg::cell_addr_t ctrl_addr,
	output logic ram_we,
	output logic ram_wdata,
	output logic load_seeds,
	output logic shift,
	output mine_pkg::mine_count_t placed,
	output logic busy,
	output logic done
);

	mine_pkg::mine_state_t state;
	mine_pkg::mine_state_t state_next;
	mine_pkg::mine_count_t count_q;
	mine_pkg::cell_addr_t clear_cnt;
	logic sweep_last;
	logic site_empty;
	logic last_mine;

	assign sweep_last = (clear_cnt == `MINE_ADDR_W'(`MINE_DEPTH - 1));
	assign site_empty = ~rdata;
	assign last_mine = site_empty && (placed + 1'b1 == count_q);

	always_comb begin
		state_next = state;
		case (state)
			mine_pkg::ST_IDLE: begin
				if (start) begin
					state_next = mine_pkg::ST_CLEAR;
				end
			end
			mine_pkg::ST_CLEAR: begin
				if (sweep_last) begin
					// zero mines skips placement entirely
					if (count_q == '0) begin
						state_next = mine_pkg::ST_FINISH;
					end else begin
						state_next = mine_pkg::ST_PROBE;
					end
				end
			end
			mine_pkg::ST_PROBE: begin
				state_next = mine_pkg::ST_DECIDE;
			end
			mine_pkg::ST_DECIDE: begin
				if (last_mine) begin
					state_next = mine_pkg::ST_FINISH;
				end else begin
					state_next = mine_pkg::ST_PROBE;
				end
			end
			mine_pkg::ST_FINISH: begin
				state_next = mine_pkg::ST_IDLE;
			end
			default: begin
				state_next = mine_pkg::ST_IDLE;
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (!resetn) begin
			state <= mine_pkg::ST_IDLE;
			count_q <= '0;
			placed <= '0;
			clear_cnt <= '0;
			done <= 1'b0;
		end else begin
			state <= state_next;
			done <= (state_next == mine_pkg::ST_FINISH);
			if (state == mine_pkg::ST_IDLE && start) begin
				count_q <= num_mines;
				placed <= '0;
				clear_cnt <= '0;
			end
			if (state == mine_pkg::ST_CLEAR) begin
				clear_cnt <= clear_cnt + 1'b1;
			end
			if (state == mine_pkg::ST_DECIDE && site_empty) begin
				placed <= placed + 1'b1;
			end
		end
	end

	// sweep address while clearing, candidate otherwise
	assign ctrl_addr = (state == mine_pkg::ST_CLEAR) ? clear_cnt : site_addr;
	assign ram_we = (state == mine_pkg::ST_CLEAR) ||
		(state == mine_pkg::ST_DECIDE && site_empty);
	assign ram_wdata = (state == mine_pkg::ST_DECIDE);
	assign load_seeds = (state == mine_pkg::ST_CLEAR) && (clear_cnt == '0);
	// every candidate advances the generators, hit or miss
	assign shift = (state == mine_pkg::ST_DECIDE);
	assign busy = (state != mine_pkg::ST_IDLE);

	a_placed_bound: assert property (
		@(posedge clock) disable iff (!resetn) placed <= count_q
	) else $error("mine_layer_ctrl: placed %0d over count %0d", placed, count_q);

	// done only in finish, and only once every mine is down
	a_done_in_finish: assert property (
		@(posedge clock) disable iff (!resetn)
			done |-> (state == mine_pkg::ST_FINISH) && (placed == count_q)
	) else $error("mine_layer_ctrl: done outside finish or short of mines");

endmodule

// ==== hw/mine_field_top.sv ====
`timescale 1ns/1ns

`include "mine_defs.svh"

module mine_field_top (
	input logic clock,
	input logic resetn,
	input logic start,
	input logic [`MINE_X_W-1:0] board_x,
	input logic [`MINE_Y_W-1:0] board_y,
	input mine_pkg::mine_count_t num_mines,
	input logic [`MINE_X_W-1:0] probe_x,
	input logic [`MINE_Y_W-1:0] probe_y,
	output logic busy,
	output logic done,
	output logic probe_mine
);

	logic [`MINE_X_W-1:0] board_x_q;
	logic [`MINE_Y_W-1:0] board_y_q;
	logic start_ok;

	mine_pkg::cell_addr_t site_addr;
	mine_pkg::cell_addr_t ctrl_addr;
	mine_pkg::cell_addr_t probe_addr;
	mine_pkg::cell_addr_t mem_addr;
	mine_pkg::mine_count_t placed;
	logic load_seeds;
	logic shift;
	logic ram_we;
	logic ram_wdata;
	logic rdata;

	assign start_ok = start && !busy;

	// board size held for the whole run
	always_ff @(posedge clock) begin
		if (start_ok) begin
			board_x_q <= board_x;
			board_y_q <= board_y;
		end
	end

	assign probe_addr = {probe_x, probe_y};
	assign mem_addr = busy ? ctrl_addr : probe_addr;
	assign probe_mine = rdata;

	mine_site_gen u_site_gen (
		.clock(clock),
		.resetn(resetn),
		.load_seeds(load_seeds),
		.shift(shift),
		.placed(placed),
		.board_x(board_x_q),
		.board_y(board_y_q),
		.site_addr(site_addr)
	);

	mine_board_ram u_board_ram (
		.clock(clock),
		.addr(mem_addr),
		.we(ram_we),
		.wdata(ram_wdata),
		.rdata(rdata)
	);

	mine_layer_ctrl u_layer_ctrl (
		.clock(clock),
		.resetn(resetn),
		.start(start),
		.num_mines(num_mines),
		.site_addr(site_addr),
		.rdata(rdata),
		.ctrl_addr(ctrl_addr),
		.ram_we(ram_we),
		.ram_wdata(ram_wdata),
		.load_seeds(load_seeds),
		.shift(shift),
		.placed(placed),
		.busy(busy),
		.done(done)
	);

endmodule

// ==== bench/mine_field_tb.sv ====
`timescale 1ns/1ns

`include "mine_defs.svh"

module mine_field_tb;

	localparam int CLOCK_PERIOD = 4;
	localparam int NUM_RANDOM = 6;
	localparam int NUM_RUNS = NUM_RANDOM + 5;
	localparam int ROWS_SPAN = 1 << `MINE_Y_W;
	localparam int PROBE_SPAN = 1 << `MINE_ADDR_W;
	localparam int NUM_FIELDS = `MINE_LFSR_COUNT * `MINE_FIELDS_PER_LFSR;
	// placement budget per run plus the full probe sweep
	localparam int RUN_CYCLES = 330 + 4 * `MINE_DEPTH + PROBE_SPAN + 8;
	localparam int WATCHDOG_NS = (NUM_RUNS * RUN_CYCLES + 20) * CLOCK_PERIOD;

	logic clock;
	logic resetn;
	logic start;
	logic [`MINE_X_W-1:0] board_x;
	logic [`MINE_Y_W-1:0] board_y;
	mine_pkg::mine_count_t num_mines;
	logic [`MINE_X_W-1:0] probe_x;
	logic [`MINE_Y_W-1:0] probe_y;
	logic busy;
	logic done;
	logic probe_mine;

	integer seed;
	int error_count;
	int check_count;
	int done_count;
	int model_candidates;
	logic [31:0] model_lfsr [`MINE_LFSR_COUNT];
	bit model_board [PROBE_SPAN];
	bit probed_board [PROBE_SPAN];
	bit saved_board [PROBE_SPAN];

	mine_field_top u_dut (
		.clock(clock),
		.resetn(resetn),
		.start(start),
		.board_x(board_x),
		.board_y(board_y),
		.num_mines(num_mines),
		.probe_x(probe_x),
		.probe_y(probe_y),
		.busy(busy),
		.done(done),
		.probe_mine(probe_mine)
	);

	initial begin
		clock = 1'b0;
		forever #(CLOCK_PERIOD / 2) clock = ~clock;
	end

	always @(negedge clock) begin
		if (resetn && done === 1'b1) begin
			done_count++;
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("timeout: no finish after %0d ns, errors so far %0d", WATCHDOG_NS, error_count);
		$display("Simulation failed");
		$finish;
	end

	function automatic int rand_in_range(input int lo, input int hi);
		int r;
		r = $random(seed);
		return lo + ((r & 32'h7fffffff) % (hi - lo + 1));
	endfunction

	function automatic logic [31:0] lfsr_step(input logic [31:0] value);
		return {value[30:0], value[22] ^ value[2] ^ value[1] ^ value[0]};
	endfunction

	task automatic step_cycle;
		@(posedge clock);
		#1;
	endtask

	task automatic check_bit(input string name, input logic got, input logic expected);
		check_count++;
		if (got !== expected) begin
			error_count++;
			$display("ERR %s got %h expected %h", name, got, expected);
		end
	endtask

	task automatic check_int(input string name, input int got, input int expected);
		check_count++;
		if (got != expected) begin
			error_count++;
			$display("ERR %s got %h expected %h", name, got, expected);
		end
	endtask

	// expected board, following the candidate rule cell by cell
	task automatic build_model(input int bx, input int by, input int mines);
		int placed;
		int field;
		int gen;
		int part;
		int col;
		int row;
		int addr;
		logic [8:0] raw;
		model_lfsr[0] = `MINE_SEED_0;
		model_lfsr[1] = `MINE_SEED_1;
		model_lfsr[2] = `MINE_SEED_2;
		model_lfsr[3] = `MINE_SEED_3;
		for (addr = 0; addr < PROBE_SPAN; addr++) begin
			model_board[addr] = 1'b0;
		end
		placed = 0;
		model_candidates = 0;
		while (placed < mines && model_candidates < (1 << 20)) begin
			field = placed % NUM_FIELDS;
			gen = field / `MINE_FIELDS_PER_LFSR;
			part = field % `MINE_FIELDS_PER_LFSR;
			raw = 9'(model_lfsr[gen] >> (`MINE_ADDR_W * part));
			col = int'(raw[8:4]) % bx;
			row = int'(raw[3:0]) % by;
			addr = col * ROWS_SPAN + row;
			if (!model_board[addr]) begin
				model_board[addr] = 1'b1;
				placed++;
			end
			model_candidates++;
			for (gen = 0; gen < `MINE_LFSR_COUNT; gen++) begin
				model_lfsr[gen] = lfsr_step(model_lfsr[gen]);
			end
		end
		if (placed < mines) begin
			error_count++;
			$display("reference model could not place %0d mines", mines);
		end
	endtask

	task automatic start_run(input int bx, input int by, input int mines);
		board_x = `MINE_X_W'(bx);
		board_y = `MINE_Y_W'(by);
		num_mines = `MINE_COUNT_W'(mines);
		start = 1'b1;
		step_cycle();
		start = 1'b0;
		check_bit("busy", busy, 1'b1);
		check_bit("done", done, 1'b0);
	endtask

	task automatic run_board(input int bx, input int by, input int mines, input bit poke);
		int cycles;
		int dones_before;
		build_model(bx, by, mines);
		dones_before = done_count;
		start_run(bx, by, mines);
		cycles = 0;
		while (done !== 1'b1) begin
			if (poke && cycles == 20) begin
				// second request in the middle of the sweep, other size and count
				board_x = `MINE_X_W'((bx % `MINE_BOARD_X_MAX) + 1);
				num_mines = `MINE_COUNT_W'(mines + 1);
				start = 1'b1;
			end else begin
				start = 1'b0;
			end
			step_cycle();
			cycles++;
		end
		start = 1'b0;
		// sweep, then two cycles per candidate
		check_int("done latency", cycles, `MINE_DEPTH + 2 * model_candidates);
		step_cycle();
		check_bit("done", done, 1'b0);
		check_bit("busy", busy, 1'b0);
		check_int("done pulses", done_count - dones_before, 1);
	endtask

	// walks the whole address space, out of bounds cells included
	task automatic probe_board(input int mines);
		int x;
		int y;
		int addr;
		int found;
		found = 0;
		for (x = 0; x < (1 << `MINE_X_W); x++) begin
			for (y = 0; y < ROWS_SPAN; y++) begin
				probe_x = `MINE_X_W'(x);
				probe_y = `MINE_Y_W'(y);
				step_cycle();
				addr = x * ROWS_SPAN + y;
				probed_board[addr] = probe_mine;
				check_count++;
				if (probe_mine !== model_board[addr]) begin
					error_count++;
					$display("ERR probe_mine x=%h y=%h got %h expected %h",
						probe_x, probe_y, probe_mine, model_board[addr]);
				end
				if (probe_mine === 1'b1) begin
					found++;
				end
			end
		end
		check_int("mine count", found, mines);
	endtask

	task automatic compare_with_saved;
		int addr;
		int diffs;
		diffs = 0;
		for (addr = 0; addr < PROBE_SPAN; addr++) begin
			if (probed_board[addr] != saved_board[addr]) begin
				diffs++;
			end
		end
		check_count++;
		if (diffs != 0) begin
			error_count++;
			$display("repeating the same inputs changed %0d cells of the board", diffs);
		end
	endtask

	initial begin
		int i;
		int bx;
		int by;
		int mines;
		int addr;
		seed = 19974;
		error_count = 0;
		check_count = 0;
		done_count = 0;
		resetn = 1'b0;
		start = 1'b0;
		board_x = `MINE_X_W'(1);
		board_y = `MINE_Y_W'(1);
		num_mines = '0;
		probe_x = '0;
		probe_y = '0;

		repeat (2) @(posedge clock);
		#1;
		resetn = 1'b1;
		check_bit("busy", busy, 1'b0);
		check_bit("done", done, 1'b0);
		step_cycle();

		for (i = 0; i < NUM_RANDOM; i++) begin
			bx = rand_in_range(1, `MINE_BOARD_X_MAX);
			by = rand_in_range(1, `MINE_BOARD_Y_MAX - 1);
			mines = rand_in_range(0, bx * by / 2);
			run_board(bx, by, mines, 1'b0);
			probe_board(mines);
		end

		// a crowded large board, then a small one over it
		bx = rand_in_range(12, `MINE_BOARD_X_MAX);
		by = rand_in_range(10, `MINE_BOARD_Y_MAX - 1);
		mines = bx * by / 2;
		run_board(bx, by, mines, 1'b0);
		probe_board(mines);
		bx = rand_in_range(2, 8);
		by = rand_in_range(2, 8);
		mines = rand_in_range(1, bx * by / 2);
		run_board(bx, by, mines, 1'b0);
		probe_board(mines);
		for (addr = 0; addr < PROBE_SPAN; addr++) begin
			saved_board[addr] = probed_board[addr];
		end
		run_board(bx, by, mines, 1'b0);
		probe_board(mines);
		compare_with_saved();

		bx = rand_in_range(1, `MINE_BOARD_X_MAX);
		by = rand_in_range(1, `MINE_BOARD_Y_MAX - 1);
		mines = rand_in_range(0, bx * by / 2);
		run_board(bx, by, mines, 1'b1);
		probe_board(mines);

		run_board(`MINE_BOARD_X_MAX, `MINE_BOARD_Y_MAX - 1, 0, 1'b0);
		probe_board(0);

		// one pulse per run, none while idle or after an ignored start
		check_int("total done pulses", done_count, NUM_RUNS);

		$display("checks %0d, errors %0d, done pulses %0d", check_count, error_count, done_count);
		if (error_count == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// ==== src.f ====
+incdir+include
hw/mine_pkg.sv
hw/mine_lfsr.sv
hw/mine_site_gen.sv
hw/mine_board_ram.sv
hw/mine_layer_ctrl.sv
hw/mine_field_top.sv
bench/mine_field_tb.sv

// ==== Makefile ====
SIM        := verilator
TOP        := mine_field_tb
FILELIST   := src.f
FLAGS      := --binary --timing -j 0
LINT_FLAGS := --lint-only --timing
BUILD_DIR  := obj_dir
LOG        := sim.log
SOURCES    := $(wildcard hw/*.sv bench/*.sv include/*.svh)

.PHONY: all lint sim clean

all: sim

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# the log decides the result, the simulator exit code alone is not enough
sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Simulation passed" $(LOG) || (echo "pass message not found in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
